// File: verilog.f
rtl/soc_pkg.sv
rtl/bus_arbiter.sv
rtl/address_map.sv
rtl/main_ram.sv
rtl/debounce.sv
rtl/gpio_port.sv
rtl/core_timer.sv
rtl/soc_fabric.sv
testbench/fabric_checker.sv
testbench/tb_soc_fabric.sv

// File: testbench/tb_soc_fabric.sv
/*
 * testbench for the system-bus fabric
 * clock and reset, stimulus table with a host driver,
 * checker instance and watchdog
 */
module tb_soc_fabric;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEB = 16;
	localparam logic [31:0] RAM  = soc_pkg::RAM_BASE;
	localparam logic [31:0] GPIO = soc_pkg::GPIO_BASE;
	localparam logic [31:0] TMR  = soc_pkg::TIMER_BASE;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_IN, OP_WAIT, OP_SIG, OP_RACE} op_e;

	// addr doubles as a cycle count for hold and wait rows
	typedef struct packed {
		logic        host;
		op_e         op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] exp;
		logic        care;
		logic        grow;
		logic        rnd;
	} row_t;

	logic clk_main;
	logic rst_n;
	logic req0;
	logic req1;
	logic gnt0;
	logic gnt1;
	soc_pkg::bus_req_t host0_req;
	soc_pkg::bus_req_t host1_req;
	soc_pkg::bus_rsp_t host0_rsp;
	soc_pkg::bus_rsp_t host1_rsp;
	logic [1:0]  sw;
	logic [1:0]  btn;
	logic [3:0]  led;
	logic        irq_gpio;
	logic        tip;
	logic        sip;
	logic [31:0] exp_data;
	logic        exp_care;
	logic        exp_grow;
	logic        sig_check;
	logic [6:0]  exp_sigs;
	int          chk_errors;
	int          drv_errors;
	int          limit_cycles;
	int          seed;
	row_t        rows[$];
	logic [31:0] shadow[logic [31:0]];

	soc_fabric dut (
		.clk_main(clk_main), .rst_n(rst_n), .req0(req0), .req1(req1),
		.host0_req(host0_req), .host1_req(host1_req), .sw(sw), .btn(btn),
		.gnt0(gnt0), .gnt1(gnt1), .host0_rsp(host0_rsp), .host1_rsp(host1_rsp),
		.led(led), .irq_gpio(irq_gpio), .tip(tip), .sip(sip)
	);

	fabric_checker u_checker (
		.clk_main(clk_main), .rst_n(rst_n), .req0(req0), .req1(req1),
		.gnt0(gnt0), .gnt1(gnt1), .host0_req(host0_req), .host1_req(host1_req),
		.host0_rsp(host0_rsp), .host1_rsp(host1_rsp), .led(led),
		.irq_gpio(irq_gpio), .tip(tip), .sip(sip), .exp_data(exp_data),
		.exp_care(exp_care), .exp_grow(exp_grow), .sig_check(sig_check),
		.exp_sigs(exp_sigs), .error_count(chk_errors)
	);

	initial begin
		clk_main = 1'b0;
		forever #20 clk_main = ~clk_main;
	end

	function automatic logic grant_of(input logic host);
		return host ? gnt1 : gnt0;
	endfunction

	function automatic logic ready_of(input logic host);
		return host ? host1_rsp.ready : host0_rsp.ready;
	endfunction

	task automatic set_req(input logic host, input logic v);
		if (host)
			req1 = v;
		else
			req0 = v;
	endtask

	task automatic drive_host(input logic host, input soc_pkg::bus_req_t r);
		if (host)
			host1_req = r;
		else
			host0_req = r;
	endtask

	task automatic wait_grant(input logic host);
		int n;
		n = 0;
		@(negedge clk_main);
		while (grant_of(host) !== 1'b1 && n < 10) begin
			@(negedge clk_main);
			n++;
		end
		if (n == 10) begin
			$display("host %0d never received a grant", host);
			drv_errors++;
		end
	endtask

	task automatic drop_req(input logic host);
		int n;
		set_req(host, 1'b0);
		n = 0;
		@(negedge clk_main);
		while (grant_of(host) !== 1'b0 && n < 8) begin
			@(negedge clk_main);
			n++;
		end
		if (n == 8) begin
			$display("host %0d kept its grant after dropping req", host);
			drv_errors++;
		end
	endtask

	// one strobe, then wait for the ready pulse
	task automatic run_transfer(input logic host, input logic we, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [31:0] exp, input logic care,
			input logic grow);
		soc_pkg::bus_req_t r;
		int n;
		r = '{addr: addr, wdata: wdata, we: we, rd: !we};
		exp_data = exp;
		exp_care = care & !we;
		exp_grow = grow & !we;
		drive_host(host, r);
		@(negedge clk_main);
		r.we = 1'b0;
		r.rd = 1'b0;
		drive_host(host, r);
		n = 0;
		while (ready_of(host) !== 1'b1 && n < 8) begin
			@(negedge clk_main);
			n++;
		end
		if (n == 8) begin
			$display("host %0d got no ready for the access at %h", host, addr);
			drv_errors++;
		end
	endtask

	task automatic add_row(input logic host, input op_e op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [31:0] exp, input logic care,
			input logic grow, input logic rnd);
		rows.push_back('{host, op, addr, wdata, exp, care, grow, rnd});
	endtask

	task automatic build_table;
		// sigs are {irq_gpio, tip, sip, led}
		add_row(0, OP_SIG, 0, 0, 7'b000_0000, 0, 0, 0);
		add_row(0, OP_WR, RAM + 32'h010, 0, 0, 0, 0, 1);
		add_row(1, OP_WR, RAM + 32'hffc, 0, 0, 0, 0, 1);
		add_row(0, OP_WR, RAM + 32'h400, 32'h1234_5678, 0, 0, 0, 0);
		add_row(1, OP_RD, RAM + 32'h010, 0, 0, 1, 0, 1);
		add_row(0, OP_RD, RAM + 32'hffc, 0, 0, 1, 0, 1);
		add_row(1, OP_RD, RAM + 32'h400, 0, 32'h1234_5678, 1, 0, 0);
		add_row(1, OP_WR, RAM + 32'h200, 0, 0, 0, 0, 1);
		add_row(0, OP_RACE, RAM + 32'h200, 0, 0, 1, 0, 1);
		add_row(0, OP_RD, 32'h4000_0000, 0, 0, 1, 0, 0);
		add_row(0, OP_WR, GPIO + soc_pkg::GPIO_LEDS, 32'ha, 0, 0, 0, 0);
		add_row(0, OP_SIG, 0, 0, 7'b000_1010, 0, 0, 0);
		add_row(1, OP_RD, GPIO + soc_pkg::GPIO_LEDS, 0, 32'ha, 1, 0, 0);
		// sw = 2'b10, btn = 2'b01
		add_row(0, OP_IN, DEB * 3, 32'h9, 0, 0, 0, 0);
		add_row(0, OP_SIG, 0, 0, 7'b100_1010, 0, 0, 0);
		add_row(0, OP_RD, GPIO + soc_pkg::GPIO_INPUTS, 0, 32'h9, 1, 0, 0);
		add_row(0, OP_RD, GPIO + soc_pkg::GPIO_IRQ_CLR, 0, 32'h1, 1, 0, 0);
		add_row(1, OP_WR, GPIO + soc_pkg::GPIO_IRQ_CLR, 0, 0, 0, 0, 0);
		add_row(0, OP_SIG, 0, 0, 7'b000_1010, 0, 0, 0);
		add_row(1, OP_RD, GPIO + soc_pkg::GPIO_IRQ_CLR, 0, 32'h0, 1, 0, 0);
		add_row(0, OP_IN, DEB * 3, 32'h0, 0, 0, 0, 0);
		add_row(0, OP_RD, GPIO + soc_pkg::GPIO_INPUTS, 0, 32'h0, 1, 0, 0);
		add_row(0, OP_WR, TMR + soc_pkg::TIMER_MTIMECMP, 32'h0, 0, 0, 0, 0);
		add_row(0, OP_SIG, 0, 0, 7'b010_1010, 0, 0, 0);
		add_row(1, OP_WR, TMR + soc_pkg::TIMER_MTIMECMP, 32'hffff_ffff, 0, 0, 0, 0);
		add_row(0, OP_SIG, 0, 0, 7'b000_1010, 0, 0, 0);
		add_row(0, OP_RD, TMR + soc_pkg::TIMER_MTIMECMP, 0, 32'hffff_ffff, 1, 0, 0);
		add_row(0, OP_RD, TMR + soc_pkg::TIMER_MTIME, 0, 0, 0, 0, 0);
		add_row(0, OP_WAIT, 40, 0, 0, 0, 0, 0);
		add_row(1, OP_RD, TMR + soc_pkg::TIMER_MTIME, 0, 0, 0, 1, 0);
		add_row(0, OP_WR, TMR + soc_pkg::TIMER_MSIP, 32'h1, 0, 0, 0, 0);
		add_row(0, OP_SIG, 0, 0, 7'b001_1010, 0, 0, 0);
		add_row(1, OP_RD, TMR + soc_pkg::TIMER_MSIP, 0, 32'h1, 1, 0, 0);
		add_row(1, OP_WR, TMR + soc_pkg::TIMER_MSIP, 32'h0, 0, 0, 0, 0);
		add_row(0, OP_SIG, 0, 0, 7'b000_1010, 0, 0, 0);
		add_row(0, OP_RD, TMR + soc_pkg::TIMER_MSIP, 0, 32'h0, 1, 0, 0);
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] data;
		logic [31:0] exp;
		data = r.wdata;
		exp  = r.exp;
		if (r.rnd && r.op == OP_WR) begin
			data = $random(seed);
			shadow[r.addr] = data;
		end
		if (r.rnd && r.op != OP_WR)
			exp = shadow[r.addr];
		case (r.op)
			OP_WR, OP_RD: begin
				set_req(r.host, 1'b1);
				wait_grant(r.host);
				run_transfer(r.host, r.op == OP_WR, r.addr, data, exp, r.care, r.grow);
				drop_req(r.host);
			end
			OP_RACE: begin
				// both hosts ask in the same idle cycle
				req0 = 1'b1;
				req1 = 1'b1;
				wait_grant(0);
				run_transfer(0, 1'b0, r.addr, data, exp, r.care, r.grow);
				drop_req(0);
				wait_grant(1);
				run_transfer(1, 1'b0, r.addr, data, exp, r.care, r.grow);
				drop_req(1);
			end
			OP_IN: begin
				{sw, btn} = r.wdata[3:0];
				repeat (r.addr) @(negedge clk_main);
			end
			OP_WAIT: repeat (r.addr) @(negedge clk_main);
			OP_SIG: begin
				exp_sigs  = r.exp[6:0];
				sig_check = 1'b1;
				@(negedge clk_main);
				sig_check = 1'b0;
			end
			default: ;
		endcase
	endtask

	initial begin
		seed       = 32'h2728_3fc6;
		drv_errors = 0;
		rst_n      = 1'b0;
		req0       = 1'b0;
		req1       = 1'b0;
		host0_req  = '0;
		host1_req  = '0;
		sw         = '0;
		btn        = '0;
		exp_data   = '0;
		exp_care   = 1'b0;
		exp_grow   = 1'b0;
		sig_check  = 1'b0;
		exp_sigs   = '0;
		build_table();
		limit_cycles = rows.size() * 20 + DEB * 8 + 200;
		repeat (10) @(negedge clk_main);
		rst_n = 1'b1;
		@(negedge clk_main);
		foreach (rows[i])
			apply_row(rows[i]);
		repeat (4) @(negedge clk_main);
		$display("errors: %0d in checker, %0d in driver", chk_errors, drv_errors);
		if (chk_errors == 0 && drv_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_main);
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		$display("errors: %0d in checker, %0d in driver", chk_errors, drv_errors);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: testbench/fabric_checker.sv
/*
 * checker for the system-bus fabric
 * models grant ownership, checks ready timing and routing,
 * compares read data and output signals with expected values
 */
module fabric_checker (
	input  logic              clk_main,
	input  logic              rst_n,
	input  logic              req0,
	input  logic              req1,
	input  logic              gnt0,
	input  logic              gnt1,
	input  soc_pkg::bus_req_t host0_req,
	input  soc_pkg::bus_req_t host1_req,
	input  soc_pkg::bus_rsp_t host0_rsp,
	input  soc_pkg::bus_rsp_t host1_rsp,
	input  logic [3:0]        led,
	input  logic              irq_gpio,
	input  logic              tip,
	input  logic              sip,
	input  logic [31:0]       exp_data,
	input  logic              exp_care,
	input  logic              exp_grow,
	input  logic              sig_check,
	input  logic [6:0]        exp_sigs,
	output int                error_count
);
	timeunit 1ns;
	timeprecision 1ps;

	// 0 idle, 1 host 0, 2 host 1
	int          owner;
	logic        pending;
	int          pend_host;
	logic        pend_rd;
	logic        pend_care;
	logic        pend_grow;
	logic [31:0] pend_exp;
	logic [31:0] last_rd;

	initial error_count = 0;

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
		error_count++;
	endtask

	task automatic problem(input string what);
		$display("ERROR at %0t: %s", $time, what);
		error_count++;
	endtask

	task automatic check_response(input int h, input soc_pkg::bus_rsp_t rsp);
		string name;
		name = $sformatf("host%0d_rsp.rdata", h);
		if (rsp.ready !== 1'b1) begin
			problem($sformatf("host %0d got no ready one cycle after its strobe", h));
		end else if (pend_rd) begin
			if (pend_care && rsp.rdata !== pend_exp)
				mismatch(name, pend_exp, rsp.rdata);
			if (pend_grow && rsp.rdata <= last_rd) begin
				$display("FAIL %0t %s expected above %h got %h", $time, name, last_rd,
					rsp.rdata);
				error_count++;
			end
			last_rd = rsp.rdata;
		end
	endtask

	always @(posedge clk_main) begin
		soc_pkg::bus_rsp_t rsp;
		logic granted;
		if (!rst_n) begin
			owner   = 0;
			pending = 1'b0;
			last_rd = '0;
		end else begin
			if (gnt0 && gnt1)
				problem("both hosts hold a grant");
			if (gnt0 !== (owner == 1))
				mismatch("gnt0", owner == 1, gnt0);
			if (gnt1 !== (owner == 2))
				mismatch("gnt1", owner == 2, gnt1);
			for (int h = 0; h < 2; h++) begin
				rsp     = h ? host1_rsp : host0_rsp;
				granted = h ? gnt1 : gnt0;
				if (pending && pend_host == h)
					check_response(h, rsp);
				else if (rsp.ready !== 1'b0)
					problem($sformatf("host %0d saw a ready it did not ask for", h));
				else if (!granted && rsp.rdata !== 32'd0)
					mismatch(h ? "host1_rsp.rdata" : "host0_rsp.rdata", 32'd0, rsp.rdata);
			end
			// a strobe from the owner opens the next response window
			pending = 1'b0;
			if (gnt0 && (host0_req.rd || host0_req.we)) begin
				pending   = 1'b1;
				pend_host = 0;
				pend_rd   = host0_req.rd;
			end else if (gnt1 && (host1_req.rd || host1_req.we)) begin
				pending   = 1'b1;
				pend_host = 1;
				pend_rd   = host1_req.rd;
			end
			pend_care = exp_care;
			pend_grow = exp_grow;
			pend_exp  = exp_data;
			if (sig_check) begin
				if (irq_gpio !== exp_sigs[6])
					mismatch("irq_gpio", exp_sigs[6], irq_gpio);
				if (tip !== exp_sigs[5])
					mismatch("tip", exp_sigs[5], tip);
				if (sip !== exp_sigs[4])
					mismatch("sip", exp_sigs[4], sip);
				if (led !== exp_sigs[3:0])
					mismatch("led", exp_sigs[3:0], led);
			end
			// ownership only moves through idle, host 0 first
			case (owner)
				0: begin
					if (req0)
						owner = 1;
					else if (req1)
						owner = 2;
				end
				1: begin
					if (!req0)
						owner = 0;
				end
				default: begin
					if (!req1)
						owner = 0;
				end
			endcase
		end
	end

endmodule

// File: rtl/soc_fabric.sv
/*
 * system-bus fabric top
 * two hosts through the arbiter, address map,
 * main RAM, gpio and core-local timer
 */
module soc_fabric #(
	parameter int ram_aw          = 10,
	parameter int debounce_cycles = 16,
	parameter int timer_div       = 4
) (
	input  logic               clk_main,
	input  logic               rst_n,
	input  logic               req0,
	input  logic               req1,
	input  soc_pkg::bus_req_t  host0_req,
	input  soc_pkg::bus_req_t  host1_req,
	input  logic [1:0]         sw,
	input  logic [1:0]         btn,
	output logic               gnt0,
	output logic               gnt1,
	output soc_pkg::bus_rsp_t  host0_rsp,
	output soc_pkg::bus_rsp_t  host1_rsp,
	output logic [3:0]         led,
	output logic               irq_gpio,
	output logic               tip,
	output logic               sip
);

	// shared bus after arbitration
	soc_pkg::bus_req_t bus_req;
	soc_pkg::bus_rsp_t bus_rsp;
	// per-target links
	soc_pkg::bus_req_t ram_req;
	soc_pkg::bus_req_t gpio_req;
	soc_pkg::bus_req_t timer_req;
	soc_pkg::bus_rsp_t ram_rsp;
	soc_pkg::bus_rsp_t gpio_rsp;
	soc_pkg::bus_rsp_t timer_rsp;

	bus_arbiter u_arbiter (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.req0(req0),
		.req1(req1),
		.host0_req(host0_req),
		.host1_req(host1_req),
		.bus_rsp(bus_rsp),
		.gnt0(gnt0),
		.gnt1(gnt1),
		.host0_rsp(host0_rsp),
		.host1_rsp(host1_rsp),
		.bus_req(bus_req)
	);

	address_map #(
		.ram_aw(ram_aw)
	) u_address_map (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.bus_req(bus_req),
		.ram_rsp(ram_rsp),
		.gpio_rsp(gpio_rsp),
		.timer_rsp(timer_rsp),
		.bus_rsp(bus_rsp),
		.ram_req(ram_req),
		.gpio_req(gpio_req),
		.timer_req(timer_req)
	);

	main_ram #(
		.ram_aw(ram_aw)
	) u_main_ram (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.bus_req(ram_req),
		.bus_rsp(ram_rsp)
	);

	gpio_port #(
		.debounce_cycles(debounce_cycles)
	) u_gpio (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.bus_req(gpio_req),
		.sw(sw),
		.btn(btn),
		.bus_rsp(gpio_rsp),
		.led(led),
		.irq_gpio(irq_gpio)
	);

	core_timer #(
		.timer_div(timer_div)
	) u_timer (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.bus_req(timer_req),
		.bus_rsp(timer_rsp),
		.tip(tip),
		.sip(sip)
	);

endmodule

// File: rtl/core_timer.sv
/*
 * core-local timer
 * prescaled mtime, writable mtimecmp and msip,
 * timer and software interrupt pending lines
 */
module core_timer #(
	parameter int timer_div = 4
) (
	input  logic               clk_main,
	input  logic               rst_n,
	input  soc_pkg::bus_req_t  bus_req,
	output soc_pkg::bus_rsp_t  bus_rsp,
	output logic               tip,
	output logic               sip
);

	localparam int DW = $clog2(timer_div + 1);

	logic [DW-1:0] div_cnt;
	logic          tick;
	logic [31:0]   mtime;
	logic [31:0]   mtimecmp;
	logic          msip;
	logic [31:0]   rdata_q;
	logic          ready_q;

	assign tick = (div_cnt == DW'(timer_div - 1));

	always_ff @(posedge clk_main or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt  <= '0;
			mtime    <= '0;
			mtimecmp <= '1;
			msip     <= 1'b0;
			ready_q  <= 1'b0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			// mtime is read only from the bus
			if (tick)
				mtime <= mtime + 32'd1;
			if (bus_req.we) begin
				case (bus_req.addr[7:0])
					soc_pkg::TIMER_MTIMECMP: mtimecmp <= bus_req.wdata;
					soc_pkg::TIMER_MSIP:     msip     <= bus_req.wdata[0];
					default: ;
				endcase
			end
			ready_q <= bus_req.rd | bus_req.we;
		end
	end

	always_ff @(posedge clk_main) begin
		if (bus_req.rd) begin
			case (bus_req.addr[7:0])
				soc_pkg::TIMER_MTIME:    rdata_q <= mtime;
				soc_pkg::TIMER_MTIMECMP: rdata_q <= mtimecmp;
				soc_pkg::TIMER_MSIP:     rdata_q <= {31'd0, msip};
				default:                 rdata_q <= 32'd0;
			endcase
		end
	end

	assign tip     = (mtime >= mtimecmp);
	assign sip     = msip;
	assign bus_rsp = '{rdata: rdata_q, ready: ready_q};

	// writes aimed at mtime leave only the prescaler step
	a_mtime_ro: assert property (@(posedge clk_main) disable iff (!rst_n)
		(bus_req.we && bus_req.addr[7:0] == soc_pkg::TIMER_MTIME)
		|=> mtime == $past(mtime) + 32'($past(tick)));

endmodule

// File: rtl/gpio_port.sv
/*
 * gpio target
 * debounced switch/button inputs, LED register,
 * sticky button-press interrupt with write-to-clear
 */
module gpio_port #(
	parameter int debounce_cycles = 16
) (
	input  logic               clk_main,
	input  logic               rst_n,
	input  soc_pkg::bus_req_t  bus_req,
	input  logic [1:0]         sw,
	input  logic [1:0]         btn,
	output soc_pkg::bus_rsp_t  bus_rsp,
	output logic [3:0]         led,
	output logic               irq_gpio
);

	logic [3:0]  inputs_d;
	logic [1:0]  btn_q;
	logic        btn_rise;
	logic [31:0] rdata_q;
	logic        ready_q;

	// switches high, buttons low
	debounce #(
		.debounce_cycles(debounce_cycles)
	) u_debounce (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.raw({sw, btn}),
		.stable(inputs_d)
	);

	assign btn_rise = |(inputs_d[1:0] & ~btn_q);

	always_ff @(posedge clk_main or negedge rst_n) begin
		if (!rst_n) begin
			btn_q    <= '0;
			led      <= '0;
			irq_gpio <= 1'b0;
			ready_q  <= 1'b0;
		end else begin
			btn_q   <= inputs_d[1:0];
			ready_q <= bus_req.rd | bus_req.we;
			if (bus_req.we && bus_req.addr[7:0] == soc_pkg::GPIO_LEDS)
				led <= bus_req.wdata[3:0];
			// a new press wins over a clear in the same cycle
			if (btn_rise)
				irq_gpio <= 1'b1;
			else if (bus_req.we && bus_req.addr[7:0] == soc_pkg::GPIO_IRQ_CLR)
				irq_gpio <= 1'b0;
		end
	end

	always_ff @(posedge clk_main) begin
		if (bus_req.rd) begin
			case (bus_req.addr[7:0])
				soc_pkg::GPIO_INPUTS:  rdata_q <= {28'd0, inputs_d};
				soc_pkg::GPIO_LEDS:    rdata_q <= {28'd0, led};
				soc_pkg::GPIO_IRQ_CLR: rdata_q <= {31'd0, irq_gpio};
				default:               rdata_q <= 32'd0;
			endcase
		end
	end

	assign bus_rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: rtl/debounce.sv
/*
 * debouncer for four raw inputs
 * two-flop synchronizer, then a per-bit stable counter
 */
module debounce #(
	parameter int debounce_cycles = 16
) (
	input  logic       clk_main,
	input  logic       rst_n,
	input  logic [3:0] raw,
	output logic [3:0] stable
);

	localparam int CW = $clog2(debounce_cycles + 1);

	logic [3:0]    sync1;
	logic [3:0]    sync2;
	logic [CW-1:0] cnt [4];

	always_ff @(posedge clk_main or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
		end else begin
			sync1 <= raw;
			sync2 <= sync1;
		end
	end

	// count while the input disagrees, restart when it agrees
	always_ff @(posedge clk_main or negedge rst_n) begin
		if (!rst_n) begin
			stable <= '0;
			for (int i = 0; i < 4; i++)
				cnt[i] <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (sync2[i] == stable[i]) begin
					cnt[i] <= '0;
				end else if (cnt[i] == CW'(debounce_cycles - 1)) begin
					stable[i] <= sync2[i];
					cnt[i]    <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

// File: rtl/main_ram.sv
/*
 * main memory
 * single-port word RAM, write on the strobe cycle,
 * registered read data and ready
 */
module main_ram #(
	parameter int ram_aw = 10
) (
	input  logic               clk_main,
	input  logic               rst_n,
	input  soc_pkg::bus_req_t  bus_req,
	output soc_pkg::bus_rsp_t  bus_rsp
);

	logic [31:0]       mem [2**ram_aw];
	logic [ram_aw-1:0] word_idx;
	logic [31:0]       rdata_q;
	logic              ready_q;

	// byte offset to word index
	assign word_idx = bus_req.addr[ram_aw+1:2];

	always_ff @(posedge clk_main) begin
		if (bus_req.we)
			mem[word_idx] <= bus_req.wdata;
		if (bus_req.rd)
			rdata_q <= mem[word_idx];
	end

	always_ff @(posedge clk_main or negedge rst_n) begin
		if (!rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= bus_req.rd | bus_req.we;
	end

	assign bus_rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: rtl/address_map.sv
/*
 * address map of the shared bus
 * decodes ram, gpio and timer windows, gates strobes to the
 * selected target and routes its response back;
 * unmapped accesses get a zero-data ready one cycle late
 */
module address_map #(
	parameter int ram_aw = 10
) (
	input  logic               clk_main,
	input  logic               rst_n,
	input  soc_pkg::bus_req_t  bus_req,
	input  soc_pkg::bus_rsp_t  ram_rsp,
	input  soc_pkg::bus_rsp_t  gpio_rsp,
	input  soc_pkg::bus_rsp_t  timer_rsp,
	output soc_pkg::bus_rsp_t  bus_rsp,
	output soc_pkg::bus_req_t  ram_req,
	output soc_pkg::bus_req_t  gpio_req,
	output soc_pkg::bus_req_t  timer_req
);

	localparam logic [31:0] RAM_BYTES = 32'd4 << ram_aw;

	logic [31:0]      ram_off;
	logic [31:0]      gpio_off;
	logic [31:0]      timer_off;
	logic             strobe;
	soc_pkg::target_e sel;
	soc_pkg::target_e resp_tgt;
	logic             none_ready;

	// offsets wrap high below a base, so one compare per window
	assign ram_off   = bus_req.addr - soc_pkg::RAM_BASE;
	assign gpio_off  = bus_req.addr - soc_pkg::GPIO_BASE;
	assign timer_off = bus_req.addr - soc_pkg::TIMER_BASE;
	assign strobe    = bus_req.rd | bus_req.we;

	always_comb begin
		if (ram_off < RAM_BYTES)
			sel = soc_pkg::TGT_RAM;
		else if (gpio_off < soc_pkg::MMIO_SPAN)
			sel = soc_pkg::TGT_GPIO;
		else if (timer_off < soc_pkg::MMIO_SPAN)
			sel = soc_pkg::TGT_TIMER;
		else
			sel = soc_pkg::TGT_NONE;
	end

	always_comb begin
		ram_req   = '{addr: ram_off, wdata: bus_req.wdata,
			we: bus_req.we & (sel == soc_pkg::TGT_RAM),
			rd: bus_req.rd & (sel == soc_pkg::TGT_RAM)};
		gpio_req  = '{addr: gpio_off, wdata: bus_req.wdata,
			we: bus_req.we & (sel == soc_pkg::TGT_GPIO),
			rd: bus_req.rd & (sel == soc_pkg::TGT_GPIO)};
		timer_req = '{addr: timer_off, wdata: bus_req.wdata,
			we: bus_req.we & (sel == soc_pkg::TGT_TIMER),
			rd: bus_req.rd & (sel == soc_pkg::TGT_TIMER)};
	end

	// remember who answers next cycle
	always_ff @(posedge clk_main or negedge rst_n) begin
		if (!rst_n) begin
			resp_tgt   <= soc_pkg::TGT_NONE;
			none_ready <= 1'b0;
		end else begin
			if (strobe)
				resp_tgt <= sel;
			none_ready <= strobe && (sel == soc_pkg::TGT_NONE);
		end
	end

	always_comb begin
		case (resp_tgt)
			soc_pkg::TGT_RAM:   bus_rsp = ram_rsp;
			soc_pkg::TGT_GPIO:  bus_rsp = gpio_rsp;
			soc_pkg::TGT_TIMER: bus_rsp = timer_rsp;
			default:            bus_rsp = '{rdata: 32'd0, ready: none_ready};
		endcase
	end

	// one target strobed at a time, the unmapped path included
	a_one_target: assert property (@(posedge clk_main) disable iff (!rst_n)
		$onehot0({ram_req.rd | ram_req.we, gpio_req.rd | gpio_req.we,
			timer_req.rd | timer_req.we, strobe && (sel == soc_pkg::TGT_NONE)}));

endmodule

// File: rtl/bus_arbiter.sv
/*
 * two-host request/grant arbiter
 * host 0 wins ties from idle, no preemption while req is held;
 * muxes the owner's request onto the shared bus and
 * returns the response to the owner only
 */
module bus_arbiter (
	input  logic               clk_main,
	input  logic               rst_n,
	input  logic               req0,
	input  logic               req1,
	input  soc_pkg::bus_req_t  host0_req,
	input  soc_pkg::bus_req_t  host1_req,
	input  soc_pkg::bus_rsp_t  bus_rsp,
	output logic               gnt0,
	output logic               gnt1,
	output soc_pkg::bus_rsp_t  host0_rsp,
	output soc_pkg::bus_rsp_t  host1_rsp,
	output soc_pkg::bus_req_t  bus_req
);

	soc_pkg::arb_state_e state;

	// ownership changes only through idle
	always_ff @(posedge clk_main or negedge rst_n) begin
		if (!rst_n) begin
			state <= soc_pkg::ARB_IDLE;
		end else begin
			case (state)
				soc_pkg::ARB_IDLE: begin
					if (req0)
						state <= soc_pkg::ARB_HOST0;
					else if (req1)
						state <= soc_pkg::ARB_HOST1;
				end
				soc_pkg::ARB_HOST0: begin
					if (!req0)
						state <= soc_pkg::ARB_IDLE;
				end
				soc_pkg::ARB_HOST1: begin
					if (!req1)
						state <= soc_pkg::ARB_IDLE;
				end
				default: state <= soc_pkg::ARB_IDLE;
			endcase
		end
	end

	assign gnt0 = (state == soc_pkg::ARB_HOST0);
	assign gnt1 = (state == soc_pkg::ARB_HOST1);

	// no owner means no strobes reach the bus
	always_comb begin
		case (state)
			soc_pkg::ARB_HOST0: bus_req = host0_req;
			soc_pkg::ARB_HOST1: bus_req = host1_req;
			default:            bus_req = '0;
		endcase
	end

	assign host0_rsp = gnt0 ? bus_rsp : '0;
	assign host1_rsp = gnt1 ? bus_rsp : '0;

	a_single_grant: assert property (@(posedge clk_main) disable iff (!rst_n)
		!(gnt0 && gnt1));

	// host side must never read and write in one cycle
	a_no_dual_strobe: assert property (@(posedge clk_main) disable iff (!rst_n)
		(gnt0 |-> !(host0_req.rd && host0_req.we)) and
		(gnt1 |-> !(host1_req.rd && host1_req.we)));

endmodule

// File: rtl/soc_pkg.sv
/*
 * shared bus types for the system-bus fabric
 * request and response structs, target and arbiter enums,
 * address windows and register offsets of the MMIO targets
 */
package soc_pkg;

	// host request, 66 bits
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        we;
		logic        rd;
	} bus_req_t;

	// target response, 33 bits
	typedef struct packed {
		logic [31:0] rdata;
		logic        ready;
	} bus_rsp_t;

	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_RAM,
		TGT_GPIO,
		TGT_TIMER
	} target_e;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_HOST0,
		ARB_HOST1
	} arb_state_e;

	// address windows
	localparam logic [31:0] RAM_BASE   = 32'h2000_0000;
	localparam logic [31:0] GPIO_BASE  = 32'h9200_0000;
	localparam logic [31:0] TIMER_BASE = 32'h9300_0000;
	localparam logic [31:0] MMIO_SPAN  = 32'h0000_0100;

	// gpio registers
	localparam logic [7:0] GPIO_INPUTS  = 8'h00;
	localparam logic [7:0] GPIO_LEDS    = 8'h04;
	localparam logic [7:0] GPIO_IRQ_CLR = 8'h08;

	// timer registers
	localparam logic [7:0] TIMER_MTIME    = 8'h00;
	localparam logic [7:0] TIMER_MTIMECMP = 8'h04;
	localparam logic [7:0] TIMER_MSIP     = 8'h08;

endpackage
